// File: synthPkg.sv
// Shared MIDI event types, oscillator direction and triangle voice constants
package synthPkg;

    // --------------------
    // MIDI

    // Status byte upper nibble, only the note commands are acted on
    typedef enum logic [3:0] {
        cmdNoteOff = 4'h8,
        cmdNoteOn  = 4'h9
    } midiCmd;

    typedef struct packed {
        midiCmd     cmd;
        logic [3:0] channel;
        logic [6:0] data0;
        logic [6:0] data1;
    } midiEvent;

    // --------------------
    // Oscillator

    typedef enum logic {
        dirUp   = 1'b0,
        dirDown = 1'b1
    } oscDir;

    localparam int sampleWidth = 18;

    // Turnaround magnitude of the triangle
    localparam int peakLevel = 65536;

    localparam int maxOctave = 10;

    // Steps for C..B of octave 10, lower octaves shift these right
    localparam logic [sampleWidth-1:0] semitoneStep [0:11] = '{
        18'd16384,
        18'd17358,
        18'd18390,
        18'd19484,
        18'd20643,
        18'd21870,
        18'd23170,
        18'd24548,
        18'd26008,
        18'd27554,
        18'd29193,
        18'd30929
    };

endpackage

// File: midiDecoder.sv
// MIDI byte parser with running status, emits note events for one channel
`timescale 1ns/1ns

module midiDecoder (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         midiByte,
    input  logic               midiByteValid,
    input  logic [3:0]         midiChannel,
    output synthPkg::midiEvent noteEvent,
    output logic               eventValid
);
    import synthPkg::*;

    // Last status byte, kept for running status
    logic [7:0] statusByte;

    // Set once the first data byte of a message is held
    logic       haveData0;
    logic [6:0] data0Reg;

    logic       isStatus;
    logic       msgDone;
    logic       cmdMatch;
    logic       chanMatch;
    logic       zeroVelOn;

    assign isStatus  = midiByte[7];
    assign msgDone   = midiByteValid && !isStatus && haveData0;
    assign cmdMatch  = (statusByte[7:4] == cmdNoteOn) || (statusByte[7:4] == cmdNoteOff);
    assign chanMatch = (statusByte[3:0] == midiChannel);

    // Note on with zero velocity means note off
    assign zeroVelOn = (statusByte[7:4] == cmdNoteOn) && (midiByte[6:0] == 7'd0);

    // --------------------
    // Byte count FSM

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            statusByte <= 8'h00;
            haveData0  <= 1'b0;
        end else if (midiByteValid) begin
            if (isStatus) begin
                statusByte <= midiByte;
                haveData0  <= 1'b0;
            end else begin
                haveData0 <= !haveData0;
            end
        end
    end

    // First data byte, note number for note messages
    always_ff @(posedge clk) begin
        if (midiByteValid && !isStatus && !haveData0) begin
            data0Reg <= midiByte[6:0];
        end
    end

    // --------------------
    // Event output

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            eventValid <= 1'b0;
        end else begin
            eventValid <= msgDone && cmdMatch && chanMatch;
        end
    end

    always_ff @(posedge clk) begin
        if (msgDone) begin
            noteEvent.cmd     <= zeroVelOn ? cmdNoteOff : midiCmd'(statusByte[7:4]);
            noteEvent.channel <= statusByte[3:0];
            noteEvent.data0   <= data0Reg;
            noteEvent.data1   <= midiByte[6:0];
        end
    end

endmodule

// File: triangleOsc.sv
// Triangle oscillator, pitch step from note and one step per sample tick
`timescale 1ns/1ns

module triangleOsc (
    input  logic                                  clk,
    input  logic                                  reset,
    input  synthPkg::midiEvent                    noteEvent,
    input  logic                                  eventValid,
    input  logic                                  sampleRateTrig,
    output logic signed [synthPkg::sampleWidth-1:0] oscVal,
    output logic                                  oscValid
);
    import synthPkg::*;

    logic [6:0] note;
    logic       noteOn;

    assign noteOn = eventValid && (noteEvent.cmd == cmdNoteOn);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            note <= 7'd0;
        end else if (noteOn) begin
            note <= noteEvent.data0;
        end
    end

    // --------------------
    // Pitch step

    logic [3:0]                     noteSemi;
    logic [3:0]                     noteOctave;
    logic [3:0]                     shiftAmt;
    logic signed [sampleWidth-1:0]  step;

    assign noteSemi   = 4'(note % 7'd12);
    assign noteOctave = 4'(note / 7'd12);
    assign shiftAmt   = 4'(maxOctave) - noteOctave;

    // Table entries are below half range, so the step stays positive
    assign step = $signed(semitoneStep[noteSemi] >> shiftAmt);

    // --------------------
    // Triangle

    logic signed [sampleWidth-1:0] value;
    logic signed [sampleWidth-1:0] valueNext;
    oscDir                         dir;

    assign valueNext = (dir == dirUp) ? value + step : value - step;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            value <= '0;
            dir   <= dirUp;
        end else if (noteOn) begin
            // Restart from zero going up
            value <= '0;
            dir   <= dirUp;
        end else if (sampleRateTrig) begin
            value <= valueNext;
            if (valueNext > peakLevel) begin
                dir <= dirDown;
            end else if (valueNext < -peakLevel) begin
                dir <= dirUp;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            oscValid <= 1'b0;
        end else begin
            oscValid <= sampleRateTrig;
        end
    end

    assign oscVal = value;

endmodule

// File: sampleGain.sv
// Velocity scaling and note gate, registered stereo output with ready strobe
`timescale 1ns/1ns

module sampleGain (
    input  logic                                    clk,
    input  logic                                    reset,
    input  synthPkg::midiEvent                      noteEvent,
    input  logic                                    eventValid,
    input  logic signed [synthPkg::sampleWidth-1:0] oscVal,
    input  logic                                    oscValid,
    output logic                                    sampleOutRdy,
    output logic signed [synthPkg::sampleWidth-1:0] sampleOutL,
    output logic signed [synthPkg::sampleWidth-1:0] sampleOutR
);
    import synthPkg::*;

    logic       gate;
    logic [6:0] heldNote;
    logic [6:0] velocity;
    logic       noteOn;
    logic       noteOff;

    assign noteOn  = eventValid && (noteEvent.cmd == cmdNoteOn);
    assign noteOff = eventValid && (noteEvent.cmd == cmdNoteOff) && (noteEvent.data0 == heldNote);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gate <= 1'b0;
        end else if (noteOn) begin
            gate <= 1'b1;
        end else if (noteOff) begin
            gate <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (noteOn) begin
            heldNote <= noteEvent.data0;
            velocity <= noteEvent.data1;
        end
    end

    // --------------------
    // Scaling

    logic signed [sampleWidth+7:0] product;
    logic signed [sampleWidth+7:0] scaled;
    logic signed [sampleWidth-1:0] sampleReg;

    assign product = oscVal * $signed({1'b0, velocity});
    assign scaled  = product >>> 7;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sampleOutRdy <= 1'b0;
            sampleReg    <= '0;
        end else begin
            sampleOutRdy <= oscValid;
            if (oscValid) begin
                sampleReg <= gate ? scaled[sampleWidth-1:0] : '0;
            end
        end
    end

    // Mono voice, both channels the same
    assign sampleOutL = sampleReg;
    assign sampleOutR = sampleReg;

endmodule

// File: triangleSynth.sv
// Monophonic MIDI triangle voice, decoder to oscillator to output stage
`timescale 1ns/1ns

module triangleSynth (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [7:0]                              midiByte,
    input  logic                                    midiByteValid,
    input  logic [3:0]                              midiChannel,
    input  logic                                    sampleRateTrig,
    output logic                                    sampleOutRdy,
    output logic signed [synthPkg::sampleWidth-1:0] sampleOutL,
    output logic signed [synthPkg::sampleWidth-1:0] sampleOutR
);
    import synthPkg::*;

    midiEvent                      noteEvent;
    logic                          eventValid;
    logic signed [sampleWidth-1:0] oscVal;
    logic                          oscValid;

    midiDecoder u_midiDecoder (
        .clk           (clk),
        .reset         (reset),
        .midiByte      (midiByte),
        .midiByteValid (midiByteValid),
        .midiChannel   (midiChannel),
        .noteEvent     (noteEvent),
        .eventValid    (eventValid)
    );

    triangleOsc u_triangleOsc (
        .clk            (clk),
        .reset          (reset),
        .noteEvent      (noteEvent),
        .eventValid     (eventValid),
        .sampleRateTrig (sampleRateTrig),
        .oscVal         (oscVal),
        .oscValid       (oscValid)
    );

    sampleGain u_sampleGain (
        .clk          (clk),
        .reset        (reset),
        .noteEvent    (noteEvent),
        .eventValid   (eventValid),
        .oscVal       (oscVal),
        .oscValid     (oscValid),
        .sampleOutRdy (sampleOutRdy),
        .sampleOutL   (sampleOutL),
        .sampleOutR   (sampleOutR)
    );

endmodule

// File: triangleSynthTb.sv
// Table-driven testbench for the MIDI triangle voice against a reference model
`timescale 1ns/1ns

module triangleSynthTb;
    import synthPkg::*;

    localparam logic [3:0] voiceChannel = 4'h5;
    localparam int drainTimeout = 16;

    typedef enum logic {
        rowByte,
        rowTick
    } rowKind;

    typedef struct packed {
        rowKind     kind;
        logic [7:0] data;
        logic [7:0] count;
    } stepRow;

    typedef struct packed {
        logic [31:0]            tickCycle;
        logic [sampleWidth-1:0] value;
    } expSample;

    logic                          clk;
    logic                          reset;
    logic [7:0]                    midiByte;
    logic                          midiByteValid;
    logic [3:0]                    midiChannel;
    logic                          sampleRateTrig;
    logic                          sampleOutRdy;
    logic signed [sampleWidth-1:0] sampleOutL;
    logic signed [sampleWidth-1:0] sampleOutR;

    stepRow   stepTable[$];
    expSample pending[$];
    int       cycle;
    int       errors;
    int       checks;
    int       seed;

    // Reference model state
    logic [7:0] mStatus;
    logic       mHaveData0;
    logic [6:0] mData0;
    int         mNote;
    int         mValue;
    oscDir      mDir;
    logic       mGate;
    int         mVel;
    int         mHeldNote;

    triangleSynth i_dut (
        .clk            (clk),
        .reset          (reset),
        .midiByte       (midiByte),
        .midiByteValid  (midiByteValid),
        .midiChannel    (midiChannel),
        .sampleRateTrig (sampleRateTrig),
        .sampleOutRdy   (sampleOutRdy),
        .sampleOutL     (sampleOutL),
        .sampleOutR     (sampleOutR)
    );

    always #4 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected 0x%0h, got 0x%0h (cycle %0d)",
                     name, expected, actual, cycle);
        end
    endtask

    task automatic addRow(input rowKind kind, input logic [7:0] data, input logic [7:0] count);
        stepRow row;
        row.kind  = kind;
        row.data  = data;
        row.count = count;
        stepTable.push_back(row);
    endtask

    // --------------------
    // Reference model

    task automatic applyEvent(input logic isOn, input int data0, input int data1);
        if (isOn) begin
            mNote     = data0;
            mValue    = 0;
            mDir      = dirUp;
            mGate     = 1'b1;
            mVel      = data1;
            mHeldNote = data0;
        end else if (data0 == mHeldNote) begin
            mGate = 1'b0;
        end
    endtask

    task automatic modelByte(input logic [7:0] b);
        if (b[7]) begin
            mStatus    = b;
            mHaveData0 = 1'b0;
        end else if (!mHaveData0) begin
            mData0     = b[6:0];
            mHaveData0 = 1'b1;
        end else begin
            mHaveData0 = 1'b0;
            if (mStatus[3:0] == voiceChannel) begin
                // Zero velocity note on counts as note off
                if (mStatus[7:4] == cmdNoteOn && b[6:0] != 7'd0) begin
                    applyEvent(1'b1, mData0, b[6:0]);
                end else if (mStatus[7:4] == cmdNoteOn || mStatus[7:4] == cmdNoteOff) begin
                    applyEvent(1'b0, mData0, 0);
                end
            end
        end
    endtask

    task automatic modelTick(output logic [sampleWidth-1:0] expected);
        int step;
        int scaled;
        step = int'(semitoneStep[mNote % 12]) >> (maxOctave - mNote / 12);
        if (mDir == dirUp) begin
            mValue = mValue + step;
        end else begin
            mValue = mValue - step;
        end
        if (mValue > peakLevel) begin
            mDir = dirDown;
        end else if (mValue < -peakLevel) begin
            mDir = dirUp;
        end
        scaled   = (mValue * mVel) >>> 7;
        expected = mGate ? scaled[sampleWidth-1:0] : '0;
    endtask

    // --------------------
    // Drivers and monitor

    // Advances one falling edge and checks any ready sample against the queue
    task automatic nextCycle();
        expSample head;
        @(negedge clk);
        cycle++;
        if (sampleOutRdy) begin
            if (pending.size() == 0) begin
                errors++;
                $display("sampleOutRdy pulsed with no sample tick outstanding (cycle %0d)",
                         cycle);
            end else begin
                head = pending.pop_front();
                checkValue("sampleOutRdy latency", 32'd2, cycle - head.tickCycle);
                checkValue("sampleOutL", head.value, $unsigned(sampleOutL));
                checkValue("sampleOutR", head.value, $unsigned(sampleOutR));
            end
        end
    endtask

    task automatic sendByte(input logic [7:0] b);
        nextCycle();
        midiByte      = b;
        midiByteValid = 1'b1;
        modelByte(b);
        nextCycle();
        midiByteValid = 1'b0;
    endtask

    task automatic drainSamples();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < drainTimeout) begin
            nextCycle();
            waited++;
        end
        if (pending.size() != 0) begin
            errors++;
            $display("Timeout: %0d sample ticks never produced sampleOutRdy", pending.size());
            pending.delete();
        end
    endtask

    // Back to back ticks keep two samples in flight at once
    task automatic sendTicks(input int n);
        int       i;
        expSample item;
        logic [sampleWidth-1:0] expValue;
        for (i = 0; i < n; i++) begin
            nextCycle();
            sampleRateTrig = 1'b1;
            modelTick(expValue);
            item.tickCycle = cycle;
            item.value     = expValue;
            pending.push_back(item);
        end
        nextCycle();
        sampleRateTrig = 1'b0;
        drainSamples();
    endtask

    initial begin
        int     n;
        int     note;
        int     vel;
        stepRow row;

        seed           = 32'hb2bc835a;
        clk            = 1'b0;
        reset          = 1'b1;
        midiByte       = 8'h00;
        midiByteValid  = 1'b0;
        midiChannel    = voiceChannel;
        sampleRateTrig = 1'b0;
        cycle          = 0;
        errors         = 0;
        checks         = 0;
        mStatus        = 8'h00;
        mHaveData0     = 1'b0;
        mData0         = 7'd0;
        mNote          = 0;
        mValue         = 0;
        mDir           = dirUp;
        mGate          = 1'b0;
        mVel           = 0;
        mHeldNote      = -1;

        // Idle voice gives zero outputs
        addRow(rowTick, 8'h00, 8'd4);

        // Random notes over several octaves
        for (n = 0; n < 4; n++) begin
            note = 12 * (3 + {$random(seed)} % 7) + {$random(seed)} % 12;
            vel  = 1 + {$random(seed)} % 127;
            addRow(rowByte, 8'h90 | voiceChannel, 8'd0);
            addRow(rowByte, 8'(note), 8'd0);
            addRow(rowByte, 8'(vel), 8'd0);
            addRow(rowTick, 8'h00, 8'd140);
        end

        // High note turns around at both peaks within a few ticks
        vel = 1 + {$random(seed)} % 127;
        addRow(rowByte, 8'h90 | voiceChannel, 8'd0);
        addRow(rowByte, 8'd124, 8'd0);
        addRow(rowByte, 8'(vel), 8'd0);
        addRow(rowTick, 8'h00, 8'd40);

        // Control change whose data would release the note under a stale status
        addRow(rowByte, 8'hB0 | voiceChannel, 8'd0);
        addRow(rowByte, 8'd124, 8'd0);
        addRow(rowByte, 8'h00, 8'd0);
        addRow(rowTick, 8'h00, 8'd4);

        // Filtered messages leave the held note sounding
        addRow(rowByte, 8'h96, 8'd0);
        addRow(rowByte, 8'd60, 8'd0);
        addRow(rowByte, 8'd100, 8'd0);
        addRow(rowTick, 8'h00, 8'd6);
        addRow(rowByte, 8'h80 | voiceChannel, 8'd0);
        addRow(rowByte, 8'd60, 8'd0);
        addRow(rowByte, 8'h40, 8'd0);
        addRow(rowTick, 8'h00, 8'd6);

        // Running status with a second note and a zero velocity release
        note = 12 * (6 + {$random(seed)} % 4) + {$random(seed)} % 12;
        vel  = 1 + {$random(seed)} % 127;
        addRow(rowByte, 8'h90 | voiceChannel, 8'd0);
        addRow(rowByte, 8'(note), 8'd0);
        addRow(rowByte, 8'(vel), 8'd0);
        addRow(rowTick, 8'h00, 8'd8);
        note = (note + 7) % 120;
        vel  = 1 + {$random(seed)} % 127;
        addRow(rowByte, 8'(note), 8'd0);
        addRow(rowByte, 8'(vel), 8'd0);
        addRow(rowTick, 8'h00, 8'd8);
        addRow(rowByte, 8'(note), 8'd0);
        addRow(rowByte, 8'h00, 8'd0);
        addRow(rowTick, 8'h00, 8'd6);

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (stepTable[i]) begin
            row = stepTable[i];
            if (row.kind == rowByte) begin
                sendByte(row.data);
            end else begin
                sendTicks(row.count);
            end
        end

        // Quiet tail catches stray ready strobes
        repeat (4) nextCycle();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
synthPkg.sv
midiDecoder.sv
triangleOsc.sv
sampleGain.sv
triangleSynth.sv
triangleSynthTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the triangle voice testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter project directory"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module triangleSynthTb -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput="$(./obj_dir/simTb)"
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
